/* rtl/decode_settings.svh */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Datapath width of registers and immediates
`define DATA_W 32

// Architectural integer registers, x0 included
`define REG_CNT 32

// Exception codes carried in exc_code
`define EXC_NONE    4'd0
`define EXC_ILLEGAL 4'd2

`endif

/* rtl/decode_pkg.sv */
`default_nettype none

`include "decode_settings.svh"

package decode_pkg;

   // Major opcode, instruction bits 6 to 2
   typedef enum logic [4:0] {
      OPC_LOAD   = 5'b00000,
      OPC_OP_IMM = 5'b00100,
      OPC_AUIPC  = 5'b00101,
      OPC_STORE  = 5'b01000,
      OPC_OP     = 5'b01100,
      OPC_LUI    = 5'b01101,
      OPC_BRANCH = 5'b11000,
      OPC_JALR   = 5'b11001,
      OPC_JAL    = 5'b11011,
      OPC_SYSTEM = 5'b11100
   } opcode_e;

   typedef enum logic [2:0] {
      IMM_NONE = 3'd0,
      IMM_I    = 3'd1,
      IMM_S    = 3'd2,
      IMM_B    = 3'd3,
      IMM_U    = 3'd4,
      IMM_J    = 3'd5
   } imm_fmt_e;

   typedef enum logic [1:0] {
      BRJ_NONE   = 2'd0,
      BRJ_BRANCH = 2'd1,
      BRJ_JAL    = 2'd2,
      BRJ_JALR   = 2'd3
   } brj_op_e;

   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_MEM = 2'd1,
      WB_PC4 = 2'd2
   } wb_sel_e;

   // Control half of the ID/EX register
   typedef struct packed {
      logic [3:0] alu_op;    // {funct7[5], funct3} style code
      logic       op1_sel;   // 1 selects PC
      logic       op2_sel;   // 1 selects immediate
      wb_sel_e    wb_sel;
      brj_op_e    brj_op;
      logic       is_load;
      logic       is_store;
      logic       is_mret;
      logic       mdu_en;
      logic [2:0] mdu_op;
      logic [2:0] funct3;
      logic [6:0] funct7;
      logic       exc_valid;
      logic [3:0] exc_code;
   } id_ex_ctrl_t;

   // Data half of the ID/EX register
   typedef struct packed {
      logic [31:2]         pc;
      logic [`DATA_W-1:0]  rs1_value;
      logic [`DATA_W-1:0]  rs2_value;
      logic [`DATA_W-1:0]  imm;
      logic [4:0]          rd;
      logic [4:0]          rs1_label;
      logic [4:0]          rs2_label;
   } id_ex_data_t;

   typedef struct packed {
      id_ex_ctrl_t ctrl;
      logic [4:0]  rd;       // Zero when nothing is written back
   } dec_out_t;

endpackage

`default_nettype wire

/* rtl/instr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_settings.svh"

module instr_decoder (
   input  logic [31:0]          instr_i,
   input  logic                 m_supported_i,
   output decode_pkg::dec_out_t dec_o
);
   import decode_pkg::*;

   localparam logic [3:0]  ALU_ADD    = 4'b0000;
   localparam logic [3:0]  ALU_COPY_B = 4'b1011;  // Unused RV code, passes operand 2
   localparam logic [31:0] MRET_WORD  = 32'h3020_0073;

   opcode_e     opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic [4:0]  rd_field;
   id_ex_ctrl_t ctrl;
   logic        reg_wr;
   logic        illegal;

   assign opcode   = opcode_e'(instr_i[6:2]);
   assign funct3   = instr_i[14:12];
   assign funct7   = instr_i[31:25];
   assign rd_field = instr_i[11:7];

   ////////////////////////////////////////////////////////////////////////////
   // Main decode
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      ctrl        = '0;
      ctrl.funct3 = funct3;
      ctrl.funct7 = funct7;
      reg_wr      = 1'b0;
      illegal     = 1'b0;

      case (opcode)
         OPC_LUI: begin
            ctrl.op2_sel = 1'b1;
            ctrl.alu_op  = ALU_COPY_B;
            reg_wr       = 1'b1;
         end
         OPC_AUIPC: begin
            ctrl.op1_sel = 1'b1;  // PC + imm
            ctrl.op2_sel = 1'b1;
            reg_wr       = 1'b1;
         end
         OPC_JAL: begin
            ctrl.op1_sel = 1'b1;
            ctrl.op2_sel = 1'b1;
            ctrl.wb_sel  = WB_PC4;
            reg_wr       = 1'b1;
         end
         OPC_JALR: begin
            ctrl.op2_sel = 1'b1;  // rs1 + imm target
            ctrl.wb_sel  = WB_PC4;
            reg_wr       = 1'b1;
         end
         OPC_BRANCH: begin
            // Compare of rs1 and rs2, kind taken from funct3 in EX
            ctrl.alu_op = ALU_ADD;
         end
         OPC_LOAD: begin
            ctrl.op2_sel = 1'b1;
            ctrl.is_load = 1'b1;
            ctrl.wb_sel  = WB_MEM;
            reg_wr       = 1'b1;
         end
         OPC_STORE: begin
            ctrl.op2_sel  = 1'b1;
            ctrl.is_store = 1'b1;
         end
         OPC_OP_IMM: begin
            ctrl.op2_sel = 1'b1;
            ctrl.alu_op  = {1'b0, funct3};
            reg_wr       = 1'b1;
            if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
               illegal = 1'b1;  // SLLI takes no funct7 bits
            end else if (funct3 == 3'b101) begin
               if (funct7 == 7'b0100000) begin
                  ctrl.alu_op = {1'b1, funct3};  // SRAI
               end else if (funct7 != 7'b0000000) begin
                  illegal = 1'b1;
               end
            end
         end
         OPC_OP: begin
            reg_wr = 1'b1;
            case (funct7)
               7'b0000000: ctrl.alu_op = {1'b0, funct3};
               7'b0100000: begin
                  if (funct3 == 3'b000 || funct3 == 3'b101) begin
                     ctrl.alu_op = {1'b1, funct3};  // SUB, SRA
                  end else begin
                     illegal = 1'b1;
                  end
               end
               7'b0000001: begin
                  // M extension only when the core has an MDU
                  if (m_supported_i) begin
                     ctrl.mdu_en = 1'b1;
                     ctrl.mdu_op = funct3;
                  end else begin
                     illegal = 1'b1;
                  end
               end
               default: illegal = 1'b1;
            endcase
         end
         OPC_SYSTEM: begin
            if (instr_i == MRET_WORD) begin
               ctrl.is_mret = 1'b1;
            end else begin
               illegal = 1'b1;  // No CSR or ECALL support
            end
         end
         default: illegal = 1'b1;
      endcase

      // Illegal words leave only the function fields and the exception
      if (illegal) begin
         ctrl        = '0;
         ctrl.funct3 = funct3;
         ctrl.funct7 = funct7;
         reg_wr      = 1'b0;
      end

      ctrl.exc_valid = illegal;
      ctrl.exc_code  = illegal ? `EXC_ILLEGAL : `EXC_NONE;
   end

   assign dec_o.ctrl = ctrl;
   assign dec_o.rd   = reg_wr ? rd_field : 5'd0;  // Stores, branches, MRET write nothing

endmodule

`default_nettype wire

/* rtl/imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_settings.svh"

module imm_gen (
   input  logic [31:0]         instr_i,
   output logic [`DATA_W-1:0]  imm_o,
   output decode_pkg::brj_op_e brj_op_o
);
   import decode_pkg::*;

   imm_fmt_e fmt;

   // Format and jump kind straight from the major opcode
   always_comb begin
      fmt      = IMM_NONE;
      brj_op_o = BRJ_NONE;
      case (opcode_e'(instr_i[6:2]))
         OPC_LOAD, OPC_OP_IMM: fmt = IMM_I;
         OPC_JALR: begin
            fmt      = IMM_I;
            brj_op_o = BRJ_JALR;
         end
         OPC_STORE: fmt = IMM_S;
         OPC_BRANCH: begin
            fmt      = IMM_B;
            brj_op_o = BRJ_BRANCH;
         end
         OPC_LUI, OPC_AUIPC: fmt = IMM_U;
         OPC_JAL: begin
            fmt      = IMM_J;
            brj_op_o = BRJ_JAL;
         end
         default: fmt = IMM_NONE;
      endcase
   end

   always_comb begin
      case (fmt)
         IMM_I:   imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
         IMM_S:   imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
         IMM_B:   imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                           instr_i[30:25], instr_i[11:8], 1'b0};
         IMM_U:   imm_o = {instr_i[31:12], 12'b0};  // Upper half, no extension
         IMM_J:   imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                           instr_i[20], instr_i[30:21], 1'b0};
         default: imm_o = '0;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_settings.svh"

module regfile (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic [4:0]          wr_rd_i,
   input  logic [`DATA_W-1:0]  wr_data_i,
   input  logic [4:0]          rs1_i,
   input  logic [4:0]          rs2_i,
   output logic [`DATA_W-1:0]  rs1_data_o,
   output logic [`DATA_W-1:0]  rs2_data_o
);

   logic [`DATA_W-1:0] regs [`REG_CNT];

   // x0 target means no write this cycle
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `REG_CNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_rd_i != 5'd0) begin
         regs[wr_rd_i] <= wr_data_i;
      end
   end

   // Reads see the value being written in the same cycle
   always_comb begin
      if (rs1_i == 5'd0)         rs1_data_o = '0;
      else if (rs1_i == wr_rd_i) rs1_data_o = wr_data_i;
      else                       rs1_data_o = regs[rs1_i];

      if (rs2_i == 5'd0)         rs2_data_o = '0;
      else if (rs2_i == wr_rd_i) rs2_data_o = wr_data_i;
      else                       rs2_data_o = regs[rs2_i];
   end

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
   input  logic       ex_is_load_i,
   input  logic [4:0] ex_rd_i,
   input  logic [4:0] id_rs1_i,
   input  logic [4:0] id_rs2_i,
   output logic       stall_o
);

   logic rs1_hit;
   logic rs2_hit;

   // Register fields are compared raw, so an unused rs2 field can match too
   assign rs1_hit = (ex_rd_i == id_rs1_i);
   assign rs2_hit = (ex_rd_i == id_rs2_i);

   // Load data is only ready after MEM, one slot too late for EX
   assign stall_o = ex_is_load_i && (ex_rd_i != 5'd0) && (rs1_hit || rs2_hit);

endmodule

`default_nettype wire

/* rtl/instruction_decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_settings.svh"

module instruction_decode_stage (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic [31:0]             instr_i,
   input  logic [31:2]             pc_i,
   input  logic [4:0]              wb_rd_i,
   input  logic [`DATA_W-1:0]      wb_data_i,
   input  logic                    busywait_i,
   input  logic                    branching_i,
   input  logic                    stall_id_i,
   input  logic                    m_supported_i,
   output logic                    load_stall_o,
   output decode_pkg::id_ex_ctrl_t ctrl_o,
   output decode_pkg::id_ex_data_t data_o
);
   import decode_pkg::*;

   dec_out_t           dec;
   brj_op_e            brj_op;
   logic [`DATA_W-1:0] imm;
   logic [`DATA_W-1:0] rs1_value;
   logic [`DATA_W-1:0] rs2_value;
   logic [4:0]         rs1_label;
   logic [4:0]         rs2_label;
   id_ex_ctrl_t        ctrl_d;
   id_ex_data_t        data_d;

   assign rs1_label = instr_i[19:15];
   assign rs2_label = instr_i[24:20];

   ////////////////////////////////////////////////////////////////////////////
   // Decode blocks
   ////////////////////////////////////////////////////////////////////////////

   instr_decoder u_decoder (
      .instr_i       (instr_i),
      .m_supported_i (m_supported_i),
      .dec_o         (dec)
   );

   imm_gen u_imm_gen (
      .instr_i  (instr_i),
      .imm_o    (imm),
      .brj_op_o (brj_op)
   );

   regfile u_regfile (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wr_rd_i    (wb_rd_i),
      .wr_data_i  (wb_data_i),
      .rs1_i      (rs1_label),
      .rs2_i      (rs2_label),
      .rs1_data_o (rs1_value),
      .rs2_data_o (rs2_value)
   );

   // EX-stage side comes from the register below
   hazard_unit u_hazard (
      .ex_is_load_i (ctrl_o.is_load),
      .ex_rd_i      (data_o.rd),
      .id_rs1_i     (rs1_label),
      .id_rs2_i     (rs2_label),
      .stall_o      (load_stall_o)
   );

   always_comb begin
      ctrl_d        = dec.ctrl;
      ctrl_d.brj_op = brj_op;  // Jump kind from the immediate generator
   end

   assign data_d = '{
      pc:        pc_i,
      rs1_value: rs1_value,
      rs2_value: rs2_value,
      imm:       imm,
      rd:        dec.rd,
      rs1_label: rs1_label,
      rs2_label: rs2_label
   };

   ////////////////////////////////////////////////////////////////////////////
   // ID/EX register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i || branching_i) begin
         ctrl_o <= '0;   // Flush
         data_o <= '0;
      end else if (busywait_i) begin
         ctrl_o <= ctrl_o;
         data_o <= data_o;
      end else if (stall_id_i) begin
         if (load_stall_o) begin
            ctrl_o <= '0;  // Bubble into EX
            data_o <= '0;
         end else begin
            ctrl_o <= ctrl_o;
            data_o <= data_o;
         end
      end else begin
         ctrl_o <= ctrl_d;
         data_o <= data_d;
      end
   end

endmodule

`default_nettype wire

/* tests/decode_stage_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage_sva (
   input logic                    clk_i,
   input logic                    rst_n_i,
   input logic                    busywait_i,
   input logic                    branching_i,
   input decode_pkg::id_ex_ctrl_t ctrl_i,
   input decode_pkg::id_ex_data_t data_i
);

   // Reset and taken branch both empty the ID/EX register
   flush_zero: assert property (@(posedge clk_i)
      (!rst_n_i || branching_i) |=> (ctrl_i == '0 && data_i == '0))
      else $error("ID/EX register not cleared after flush");

   hold_stable: assert property (@(posedge clk_i)
      (rst_n_i && busywait_i && !branching_i) |=> ($stable(ctrl_i) && $stable(data_i)))
      else $error("ID/EX register changed during busywait");

   // A trapped word must not start a memory or MDU access
   exc_quiet: assert property (@(posedge clk_i)
      ctrl_i.exc_valid |-> !(ctrl_i.is_load || ctrl_i.is_store || ctrl_i.mdu_en))
      else $error("Enable set on an illegal instruction");

endmodule

bind instruction_decode_stage decode_stage_sva sva0 (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .busywait_i  (busywait_i),
   .branching_i (branching_i),
   .ctrl_i      (ctrl_o),
   .data_i      (data_o)
);

`default_nettype wire

/* tests/tb_decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_settings.svh"

module tb_decode_stage;
   import decode_pkg::*;

   localparam int N_RAND      = 8;                      // Words per instruction kind
   localparam int TEST_CYCLES = 80 + 20 * N_RAND;
   localparam int TIMEOUT_NS  = TEST_CYCLES * 10 + 500;

   logic               clk_i;
   logic               rst_n_i;
   logic [31:0]        instr_i;
   logic [31:2]        pc_i;
   logic [4:0]         wb_rd_i;
   logic [`DATA_W-1:0] wb_data_i;
   logic               busywait_i;
   logic               branching_i;
   logic               stall_id_i;
   logic               m_supported_i;
   logic               load_stall_o;
   id_ex_ctrl_t        ctrl_o;
   id_ex_data_t        data_o;

   logic [31:0] rf_model [32];   // Expected register contents

   instruction_decode_stage dut0 (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .instr_i       (instr_i),
      .pc_i          (pc_i),
      .wb_rd_i       (wb_rd_i),
      .wb_data_i     (wb_data_i),
      .busywait_i    (busywait_i),
      .branching_i   (branching_i),
      .stall_id_i    (stall_id_i),
      .m_supported_i (m_supported_i),
      .load_stall_o  (load_stall_o),
      .ctrl_o        (ctrl_o),
      .data_o        (data_o)
   );

   always #5 clk_i = ~clk_i;

   initial begin
      #(TIMEOUT_NS);
      report_failure("Timeout, the tests did not finish in time");
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checking helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         report_failure($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_zero_outputs(input string what);
      assert (ctrl_o === '0 && data_o === '0) else begin
         report_failure($sformatf("ERR %0t ctrl_o/data_o after %s got %h/%h expected 0",
                                  $time, what, ctrl_o, data_o));
      end
   endtask

   // Reference decoder, from the RV32IM encoding rules
   task automatic ref_decode(input logic [31:0] ins, input logic msup,
                             output id_ex_ctrl_t c, output logic [4:0] rd,
                             output logic [31:0] imm);
      logic [2:0] f3;
      logic [6:0] f7;
      logic       wr;
      logic       legal;
      f3    = ins[14:12];
      f7    = ins[31:25];
      c     = '0;
      wr    = 1'b0;
      legal = 1'b1;
      imm   = '0;
      case (ins[6:2])
         5'b01101: begin   // LUI
            wr        = 1'b1;
            c.op2_sel = 1'b1;
            c.alu_op  = 4'b1011;   // Operand 2 passed through
            imm       = {ins[31:12], 12'h000};
         end
         5'b00101: begin   // AUIPC
            wr        = 1'b1;
            c.op1_sel = 1'b1;
            c.op2_sel = 1'b1;
            imm       = {ins[31:12], 12'h000};
         end
         5'b11011: begin
            wr        = 1'b1;
            c.op1_sel = 1'b1;
            c.op2_sel = 1'b1;
            c.wb_sel  = WB_PC4;
            c.brj_op  = BRJ_JAL;
            imm       = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         end
         5'b11001: begin
            wr        = 1'b1;
            c.op2_sel = 1'b1;
            c.wb_sel  = WB_PC4;
            c.brj_op  = BRJ_JALR;
            imm       = {{21{ins[31]}}, ins[30:20]};
         end
         5'b11000: begin
            c.brj_op = BRJ_BRANCH;
            imm      = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         end
         5'b00000: begin
            wr        = 1'b1;
            c.op2_sel = 1'b1;
            c.is_load = 1'b1;
            c.wb_sel  = WB_MEM;
            imm       = {{21{ins[31]}}, ins[30:20]};
         end
         5'b01000: begin
            c.op2_sel  = 1'b1;
            c.is_store = 1'b1;
            imm        = {{21{ins[31]}}, ins[30:25], ins[11:7]};
         end
         5'b00100: begin
            wr        = 1'b1;
            c.op2_sel = 1'b1;
            c.alu_op  = {(f3 == 3'b101) && f7[5], f3};   // SRAI sets the top bit
            imm       = {{21{ins[31]}}, ins[30:20]};
            legal     = (f3 != 3'b001 || f7 == 7'h00) &&
                        (f3 != 3'b101 || f7 == 7'h00 || f7 == 7'h20);
         end
         5'b01100: begin
            wr       = 1'b1;
            legal    = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)) ||
                       (f7 == 7'h01 && msup);
            c.alu_op = (f7 == 7'h01) ? 4'h0 : {f7[5], f3};
            c.mdu_en = (f7 == 7'h01);
            c.mdu_op = (f7 == 7'h01) ? f3 : 3'b000;
         end
         5'b11100: begin
            legal     = (ins == 32'h3020_0073);   // MRET only
            c.is_mret = legal;
         end
         default: legal = 1'b0;
      endcase
      if (!legal) begin
         c  = '0;
         wr = 1'b0;
      end
      c.funct3    = f3;
      c.funct7    = f7;
      c.exc_valid = !legal;
      c.exc_code  = legal ? `EXC_NONE : `EXC_ILLEGAL;
      rd          = wr ? ins[11:7] : 5'd0;
   endtask

   task automatic check_stage(input logic [31:0] ins);
      id_ex_ctrl_t ec;
      logic [4:0]  erd;
      logic [31:0] eimm;
      ref_decode(ins, m_supported_i, ec, erd, eimm);
      check_val("ctrl_o.exc_valid", 32'(ctrl_o.exc_valid), 32'(ec.exc_valid));
      check_val("ctrl_o.exc_code", 32'(ctrl_o.exc_code), 32'(ec.exc_code));
      check_val("ctrl_o.alu_op", 32'(ctrl_o.alu_op), 32'(ec.alu_op));
      check_val("ctrl_o.op1_sel", 32'(ctrl_o.op1_sel), 32'(ec.op1_sel));
      check_val("ctrl_o.op2_sel", 32'(ctrl_o.op2_sel), 32'(ec.op2_sel));
      check_val("ctrl_o.is_load", 32'(ctrl_o.is_load), 32'(ec.is_load));
      check_val("ctrl_o.is_store", 32'(ctrl_o.is_store), 32'(ec.is_store));
      check_val("ctrl_o.is_mret", 32'(ctrl_o.is_mret), 32'(ec.is_mret));
      check_val("ctrl_o.mdu_en", 32'(ctrl_o.mdu_en), 32'(ec.mdu_en));
      check_val("ctrl_o.mdu_op", 32'(ctrl_o.mdu_op), 32'(ec.mdu_op));
      check_val("ctrl_o.wb_sel", 32'(ctrl_o.wb_sel), 32'(ec.wb_sel));
      check_val("ctrl_o.brj_op", 32'(ctrl_o.brj_op), 32'(ec.brj_op));
      check_val("ctrl_o.funct3", 32'(ctrl_o.funct3), 32'(ec.funct3));
      check_val("ctrl_o.funct7", 32'(ctrl_o.funct7), 32'(ec.funct7));
      check_val("data_o.pc", 32'(data_o.pc), 32'(pc_i));
      check_val("data_o.imm", data_o.imm, eimm);
      check_val("data_o.rd", 32'(data_o.rd), 32'(erd));
      check_val("data_o.rs1_label", 32'(data_o.rs1_label), 32'(ins[19:15]));
      check_val("data_o.rs2_label", 32'(data_o.rs2_label), 32'(ins[24:20]));
      check_val("data_o.rs1_value", data_o.rs1_value, rf_model[ins[19:15]]);
      check_val("data_o.rs2_value", data_o.rs2_value, rf_model[ins[24:20]]);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] op_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [4:0] rd);
      return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
   endfunction

   // Random legal word of one instruction kind
   function automatic logic [31:0] make_instr(input int kind);
      logic [31:0] w;
      logic [31:0] r;
      w = $urandom();
      r = $urandom();
      case (kind)
         0: w[6:0] = 7'b0110111;
         1: w[6:0] = 7'b0010111;
         2: w[6:0] = 7'b1101111;
         3: begin
            w[6:0]   = 7'b1100111;
            w[14:12] = 3'b000;
         end
         4: w[6:0] = 7'b1100011;
         5: w[6:0] = 7'b0000011;
         6: w[6:0] = 7'b0100011;
         7: begin
            w[6:0] = 7'b0010011;
            if (w[13:12] == 2'b01) begin
               w[31:25] = (w[14] && r[0]) ? 7'h20 : 7'h00;   // Shift amounts only
            end
         end
         8: begin
            w[6:0]   = 7'b0110011;
            w[31:25] = r[0] ? 7'h01 : 7'h00;
            if (r[1] && (w[14:12] == 3'b000 || w[14:12] == 3'b101)) begin
               w[31:25] = 7'h20;   // SUB, SRA
            end
         end
         default: w = 32'h3020_0073;
      endcase
      return w;
   endfunction

   // One word through the stage, checked after the edge that loads it
   task automatic run_instr(input logic [31:0] ins, input logic [4:0] wrd,
                            input logic [31:0] wdata, input logic msup);
      logic [31:0] r;
      r = $urandom();
      @(posedge clk_i);
      instr_i       <= ins;
      pc_i          <= r[31:2];
      wb_rd_i       <= wrd;
      wb_data_i     <= wdata;
      m_supported_i <= msup;
      if (wrd != 5'd0) begin
         rf_model[wrd] = wdata;
      end
      @(posedge clk_i);
      @(negedge clk_i);
      check_stage(ins);
   endtask

   task automatic load_then_use(input logic [31:0] ld, input logic [31:0] nxt,
                                input logic exp);
      @(posedge clk_i);
      instr_i    <= ld;
      wb_rd_i    <= 5'd0;
      stall_id_i <= 1'b0;
      @(posedge clk_i);             // Load now in EX
      instr_i    <= nxt;
      stall_id_i <= exp;            // Controller answers load_stall_o
      @(negedge clk_i);
      check_val("load_stall_o", 32'(load_stall_o), 32'(exp));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_reset();
      @(negedge clk_i);
      check_zero_outputs("reset");
   endtask

   task automatic test_decode();
      for (int k = 0; k < 10; k++) begin
         repeat (N_RAND) begin
            run_instr(make_instr(k), 5'd0, 32'h0, 1'b1);
         end
      end
   endtask

   task automatic test_regfile();
      logic [31:0] r;
      logic [4:0]  ra;
      logic [4:0]  rb;
      for (int i = 0; i < 4; i++) begin
         r  = $urandom();
         ra = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
         rb = (r[9:5] == 5'd0) ? 5'd2 : r[9:5];
         run_instr(op_word(rb, ra, r[14:10]), ra, $urandom(), 1'b1);   // Write-through
         run_instr(op_word(ra, rb, r[14:10]), 5'd0, 32'h0, 1'b1);
      end
      run_instr(op_word(5'd0, 5'd0, 5'd3), 5'd0, 32'hdead_beef, 1'b1);
   endtask

   task automatic test_load_use();
      logic [31:0] ld;
      logic [31:0] dep;
      ld = {12'h010, 5'd2, 3'b010, 5'd5, 7'b0000011};   // lw x5, 16(x2)
      for (int i = 0; i < 2; i++) begin
         dep = (i == 0) ? op_word(5'd6, 5'd5, 5'd7) : op_word(5'd5, 5'd6, 5'd7);
         load_then_use(ld, dep, 1'b1);
         @(posedge clk_i);
         stall_id_i <= 1'b0;
         @(negedge clk_i);
         check_zero_outputs("load-use bubble");
         check_val("load_stall_o", 32'(load_stall_o), 32'd0);
         @(posedge clk_i);
         @(negedge clk_i);
         check_stage(dep);
      end
      load_then_use(ld, op_word(5'd9, 5'd8, 5'd7), 1'b0);
      load_then_use({12'h010, 5'd2, 3'b010, 5'd0, 7'b0000011}, op_word(5'd0, 5'd0, 5'd7), 1'b0);
   endtask

   task automatic test_hold_flush();
      logic [31:0] a;
      logic [31:0] b;
      a = make_instr(0);
      b = make_instr(2);
      run_instr(a, 5'd0, 32'h0, 1'b1);
      @(posedge clk_i);
      instr_i    <= b;
      busywait_i <= 1'b1;
      @(posedge clk_i);
      busywait_i <= 1'b0;
      stall_id_i <= 1'b1;           // No load in EX, so a plain hold
      @(negedge clk_i);
      check_stage(a);
      @(posedge clk_i);
      stall_id_i  <= 1'b0;
      busywait_i  <= 1'b1;
      branching_i <= 1'b1;
      @(negedge clk_i);
      check_stage(a);
      @(posedge clk_i);
      busywait_i  <= 1'b0;
      branching_i <= 1'b0;
      @(negedge clk_i);
      check_zero_outputs("branch flush under busywait");
      @(posedge clk_i);
      @(negedge clk_i);
      check_stage(b);
   endtask

   task automatic check_illegal();
      check_val("ctrl_o.exc_valid", 32'(ctrl_o.exc_valid), 32'd1);
      check_val("ctrl_o.exc_code", 32'(ctrl_o.exc_code), 32'(`EXC_ILLEGAL));
      check_val("ctrl_o.is_load", 32'(ctrl_o.is_load), 32'd0);
      check_val("ctrl_o.is_store", 32'(ctrl_o.is_store), 32'd0);
      check_val("ctrl_o.mdu_en", 32'(ctrl_o.mdu_en), 32'd0);
   endtask

   task automatic test_illegal();
      logic [31:0] div_w;
      div_w = {7'h01, 5'd3, 5'd4, 3'b100, 5'd8, 7'b0110011};   // div x8, x4, x3
      run_instr(div_w, 5'd0, 32'h0, 1'b0);
      check_illegal();
      run_instr(32'h0000_047f, 5'd0, 32'h0, 1'b1);
      check_illegal();
      run_instr({7'h40, 5'd3, 5'd4, 3'b000, 5'd8, 7'b0110011}, 5'd0, 32'h0, 1'b1);
      check_illegal();
      run_instr(div_w, 5'd0, 32'h0, 1'b1);
      check_val("ctrl_o.mdu_en", 32'(ctrl_o.mdu_en), 32'd1);
      check_val("ctrl_o.mdu_op", 32'(ctrl_o.mdu_op), 32'd4);
   endtask

   initial begin
      void'($urandom(80268));
      clk_i         = 1'b0;
      rst_n_i       = 1'b0;
      instr_i       = 32'h0000_0013;   // addi x0, x0, 0
      pc_i          = '0;
      wb_rd_i       = 5'd0;
      wb_data_i     = '0;
      busywait_i    = 1'b0;
      branching_i   = 1'b0;
      stall_id_i    = 1'b0;
      m_supported_i = 1'b1;
      for (int i = 0; i < 32; i++) begin
         rf_model[i] = '0;
      end
      repeat (4) @(posedge clk_i);
      rst_n_i <= 1'b1;
      test_reset();
      test_decode();
      test_regfile();
      test_load_use();
      test_hold_flush();
      test_illegal();
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/decode_pkg.sv
rtl/instr_decoder.sv
rtl/imm_gen.sv
rtl/regfile.sv
rtl/hazard_unit.sv
rtl/instruction_decode_stage.sv
tests/decode_stage_sva.sv
tests/tb_decode_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_decode_stage
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/Vtb_decode_stage)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
   exit 0
else
   exit 1
fi
